// File: Makefile
# Verilator build and run of the fetch predictor testbench
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fetchPredictTb
FILELIST  := project.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) include/fetchPredict.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the simulator exits non-zero when the testbench stops on an error
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

// File: bench/fetchPredictModel.sv
// reference model of the fetch return-address predictor
// keeps its own circular stack, mirrored so that it grows upward
// and applies the next-PC rule once for every accepted group
`timescale 1ns/10ps

module fetchPredictModel (
	input  logic                                   clk2x,
	input  logic                                   rst,
	input  logic                                   grpValid,
	input  logic                                   grpReady,
	input  logic [fetchPredictPkg::addrWidth-1:0]  grpPc,
	input  logic [fetchPredictPkg::instrWidth-1:0] grpInstr0,
	input  logic [fetchPredictPkg::instrWidth-1:0] grpInstr1,
	input  logic [fetchPredictPkg::slotCount-1:0]  grpSlotValid,
	output logic [fetchPredictPkg::addrWidth-1:0]  expPc,
	output int unsigned                            expCount
);
	import fetchPredictPkg::*;

	localparam int unsigned topWidth = $clog2(stackDepth);

	logic [addrWidth-1:0] stack [stackDepth];
	logic [topWidth-1:0] top;

	// a zero length field still takes up one byte
	function automatic logic [addrWidth-1:0] byteLen(input logic [instrWidth-1:0] w);
		return (w[4:2] == 3'd0) ? 32'd1 : {29'd0, w[4:2]};
	endfunction

	// upper 20 bits hold a signed offset from the slot's own PC
	function automatic logic [addrWidth-1:0] offsetTarget(input logic [addrWidth-1:0] pc,
			input logic [instrWidth-1:0] w);
		return pc + {{12{w[31]}}, w[31:12]};
	endfunction

	function automatic slotKindT kindOf(input logic [instrWidth-1:0] w, input logic v);
		slotKindT k;
		k = kindOther;
		if (v && w[1:0] == 2'd1) begin
			k = (w[11:5] == noLinkReg) ? kindJump : kindCall;
		end else if (v && w[1:0] == 2'd2) begin
			k = kindRet;
		end
		return k;
	endfunction

	// for slot 1 the return address is also the fall-through PC of the group
	task automatic applySlot(input slotKindT k, input logic [addrWidth-1:0] retA,
			input logic [addrWidth-1:0] tgt, output logic [addrWidth-1:0] next);
		case (k)
			kindCall: begin
				top = top + topWidth'(1);
				stack[top] = retA;
				next = tgt;
			end
			kindRet: begin
				next = stack[top];
				top = top - topWidth'(1);
			end
			kindJump: next = tgt;
			default: next = retA;
		endcase
	endtask

	always @(posedge clk2x) begin
		logic [addrWidth-1:0] pc1;
		logic [addrWidth-1:0] next;
		slotKindT k0;
		slotKindT k1;
		if (rst) begin
			foreach (stack[i]) begin
				stack[i] = resetPc;
			end
			top = '0;
			expCount <= 32'd0;
		end else if (grpValid && grpReady) begin
			pc1 = grpPc + byteLen(grpInstr0);
			k0 = kindOf(grpInstr0, grpSlotValid[0]);
			k1 = kindOf(grpInstr1, grpSlotValid[1]);
			// slot 1 only decides when slot 0 is ordinary
			if (k0 != kindOther) begin
				applySlot(k0, pc1, offsetTarget(grpPc, grpInstr0), next);
			end else begin
				applySlot(k1, pc1 + byteLen(grpInstr1), offsetTarget(pc1, grpInstr1), next);
			end
			expPc <= next;
			expCount <= expCount + 32'd1;
		end
	end

endmodule

// File: bench/fetchPredictTb.sv
// testbench for the fetch return-address predictor
// clock, reset, LFSR stimulus, falling-edge driver and monitor
// timeout watchdog and the single value check
`timescale 1ns/10ps

module fetchPredictTb;
	import fetchPredictPkg::*;

	localparam int unsigned resetCycles = 8;
	localparam int unsigned randomGroups = 300;

	logic clk2x;
	logic rst;
	logic grpValid;
	logic grpReady;
	logic [addrWidth-1:0] grpPc;
	logic [instrWidth-1:0] grpInstr0;
	logic [instrWidth-1:0] grpInstr1;
	logic [slotCount-1:0] grpSlotValid;
	logic predValid;
	logic predReady;
	logic [addrWidth-1:0] predPc;
	logic [addrWidth-1:0] modelPc;
	int unsigned modelCount;

	// groups still to send and predictions still owed by the DUT
	logic [addrWidth-1:0] pcQ[$];
	logic [instrWidth-1:0] instr0Q[$];
	logic [instrWidth-1:0] instr1Q[$];
	logic [slotCount-1:0] validQ[$];
	string nameQ[$];
	logic [addrWidth-1:0] expQ[$];
	string expNameQ[$];

	logic [31:0] lfsr;
	string curName;
	logic holdGroup;
	logic heldLast;
	logic [addrWidth-1:0] heldPcVal;
	int unsigned seenCount;
	int unsigned predCount;
	int unsigned totalGroups;
	int unsigned cycleLimit;
	int unsigned cycleCount = 0;

	initial clk2x = 1'b0;
	always #50 clk2x = ~clk2x;

	fetchPredictTop DUT (
		.clk2x(clk2x), .rst(rst), .grpValid(grpValid), .grpReady(grpReady),
		.grpPc(grpPc), .grpInstr0(grpInstr0), .grpInstr1(grpInstr1),
		.grpSlotValid(grpSlotValid), .predValid(predValid), .predReady(predReady),
		.predPc(predPc)
	);

	fetchPredictModel model (
		.clk2x(clk2x), .rst(rst), .grpValid(grpValid), .grpReady(grpReady),
		.grpPc(grpPc), .grpInstr0(grpInstr0), .grpInstr1(grpInstr1),
		.grpSlotValid(grpSlotValid), .expPc(modelPc), .expCount(modelCount)
	);

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			abortRun($sformatf("Mismatch in %s: expected %h, actual %h", testName, expected,
				actual));
		end
	endtask

	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic takeBits(input int unsigned count, output logic [31:0] value);
		value = '0;
		for (int unsigned i = 0; i < count; i++) begin
			lfsr = lfsrNext(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] mkInstr(input logic [1:0] cls, input logic [2:0] len,
			input logic [6:0] link, input logic [19:0] off);
		return {off, link, len, cls};
	endfunction

	task automatic queueGroup(input string name, input logic [31:0] pc,
			input logic [31:0] i0, input logic [31:0] i1, input logic [1:0] sv);
		nameQ.push_back(name);
		pcQ.push_back(pc);
		instr0Q.push_back(i0);
		instr1Q.push_back(i1);
		validQ.push_back(sv);
	endtask

	// six picks out of eight become a jump-and-link or a return
	task automatic randomInstr(output logic [31:0] instr);
		logic [31:0] pick;
		logic [31:0] len;
		logic [31:0] link;
		logic [31:0] noLinkPick;
		logic [31:0] off;
		logic [1:0] cls;
		takeBits(3, pick);
		takeBits(3, len);
		takeBits(7, link);
		takeBits(2, noLinkPick);
		takeBits(20, off);
		if (pick < 3) begin
			cls = 2'd1;
		end else if (pick < 6) begin
			cls = 2'd2;
		end else begin
			cls = (pick == 6) ? 2'd0 : 2'd3;
		end
		// one jump in four names the no-link register
		if (noLinkPick == 0) begin
			link = 32'd96;
		end
		instr = mkInstr(cls, len[2:0], link[6:0], off[19:0]);
	endtask

	task automatic buildStimulus();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pc;
		logic [31:0] sv;
		queueGroup("resetReturn", 32'h1000, mkInstr(2'd2, 3'd2, 7'd0, 20'd0), 32'd0, 2'b01);
		// three nested calls with two of them in slot 1 are unwound by returns in both slots
		queueGroup("nestedCalls", 32'h2000, mkInstr(2'd1, 3'd4, 7'd1, 20'h00100), 32'd0, 2'b01);
		queueGroup("nestedCalls", 32'h3000, mkInstr(2'd0, 3'd3, 7'd0, 20'd0),
			mkInstr(2'd1, 3'd5, 7'd1, 20'hFFF00), 2'b11);
		queueGroup("nestedCalls", 32'h4000, mkInstr(2'd0, 3'd0, 7'd0, 20'd0),
			mkInstr(2'd1, 3'd6, 7'd2, 20'h00040), 2'b11);
		queueGroup("nestedCalls", 32'h5000, mkInstr(2'd2, 3'd1, 7'd0, 20'd0), 32'd0, 2'b01);
		queueGroup("nestedCalls", 32'h5100, mkInstr(2'd0, 3'd2, 7'd0, 20'd0),
			mkInstr(2'd2, 3'd1, 7'd0, 20'd0), 2'b11);
		queueGroup("nestedCalls", 32'h5200, mkInstr(2'd2, 3'd3, 7'd0, 20'd0), 32'd0, 2'b01);
		// jumps through register 96 leave the stack alone
		queueGroup("plainJump", 32'h6000, mkInstr(2'd1, 3'd7, 7'd5, 20'h00800), 32'd0, 2'b01);
		queueGroup("plainJump", 32'h7000, mkInstr(2'd1, 3'd2, 7'd96, 20'h00200), 32'd0, 2'b01);
		queueGroup("plainJump", 32'h7100, mkInstr(2'd3, 3'd2, 7'd0, 20'd0),
			mkInstr(2'd1, 3'd4, 7'd96, 20'hFFFF0), 2'b11);
		queueGroup("plainJump", 32'h7200, mkInstr(2'd2, 3'd1, 7'd0, 20'd0), 32'd0, 2'b01);
		queueGroup("slot0Transfer", 32'h8000, mkInstr(2'd1, 3'd2, 7'd96, 20'h00010),
			mkInstr(2'd1, 3'd3, 7'd4, 20'h00020), 2'b11);
		queueGroup("slot0Transfer", 32'h8100, mkInstr(2'd1, 3'd4, 7'd3, 20'h00030),
			mkInstr(2'd2, 3'd2, 7'd0, 20'd0), 2'b11);
		queueGroup("slot0Transfer", 32'h8200, mkInstr(2'd0, 3'd2, 7'd0, 20'd0),
			mkInstr(2'd1, 3'd3, 7'd4, 20'h00050), 2'b01);
		queueGroup("slot0Transfer", 32'h8300, mkInstr(2'd0, 3'd1, 7'd0, 20'd0),
			mkInstr(2'd2, 3'd3, 7'd0, 20'd0), 2'b01);
		queueGroup("slot0Transfer", 32'h8400, mkInstr(2'd2, 3'd1, 7'd0, 20'd0), 32'd0, 2'b01);
		queueGroup("slot0Transfer", 32'h8500, mkInstr(2'd2, 3'd1, 7'd0, 20'd0), 32'd0, 2'b01);
		// twenty deep overruns the sixteen entries
		for (int i = 0; i < 20; i++) begin
			queueGroup("stackWrap", 32'h10000 + 32'h40 * i,
				mkInstr(2'd1, 3'd4, 7'd1, 20'h00040), 32'd0, 2'b01);
		end
		for (int i = 0; i < 20; i++) begin
			queueGroup("stackWrap", 32'h20000 + 32'h10 * i,
				mkInstr(2'd2, 3'd2, 7'd0, 20'd0), 32'd0, 2'b01);
		end
		for (int unsigned i = 0; i < randomGroups; i++) begin
			randomInstr(a);
			randomInstr(b);
			takeBits(32, pc);
			takeBits(2, sv);
			queueGroup("random", pc, a, b, sv[1:0]);
		end
	endtask

	// ==================================================
	// driver and monitor
	// ==================================================

	// everything read here holds still until the next rising edge
	task automatic sampleOutputs();
		if (modelCount != seenCount) begin
			expQ.push_back(modelPc);
			seenCount = modelCount;
		end
		if (heldLast) begin
			checkValue("heldPrediction", 32'd1, {31'd0, predValid});
			checkValue("heldPrediction", heldPcVal, predPc);
		end
		// a stalled prediction keeps the next group out
		if (predValid && !predReady) begin
			checkValue("stallBlocksGroups", 32'd0, {31'd0, grpReady});
		end
		// with no group in flight the sequencer has to be idle and ready
		if (expNameQ.size() == 0) begin
			checkValue("readyWhenIdle", 32'd1, {31'd0, grpReady});
		end
		if (grpValid && grpReady) begin
			expNameQ.push_back(curName);
		end
		if (predValid && predReady) begin
			if (expQ.size() == 0) begin
				abortRun("the DUT produced a prediction with no accepted group to match it");
			end else begin
				checkValue(expNameQ.pop_front(), expQ.pop_front(), predPc);
				predCount++;
			end
		end
		heldLast = predValid && !predReady;
		heldPcVal = predPc;
		holdGroup = grpValid && !grpReady;
	endtask

	task automatic runCycle();
		logic [31:0] coin;
		@(negedge clk2x);
		// a group that was offered and not taken stays on the bus unchanged
		if (!holdGroup) begin
			takeBits(1, coin);
			if (pcQ.size() > 0 && coin[0]) begin
				grpValid = 1'b1;
				grpPc = pcQ.pop_front();
				grpInstr0 = instr0Q.pop_front();
				grpInstr1 = instr1Q.pop_front();
				grpSlotValid = validQ.pop_front();
				curName = nameQ.pop_front();
			end else begin
				grpValid = 1'b0;
			end
		end
		// ready three times out of four
		takeBits(2, coin);
		predReady = (coin[1:0] != 2'd0);
		#1;
		sampleOutputs();
	endtask

	initial begin
		lfsr = 32'hf347ccb2;
		rst = 1'b1;
		grpValid = 1'b0;
		grpPc = '0;
		grpInstr0 = '0;
		grpInstr1 = '0;
		grpSlotValid = '0;
		predReady = 1'b0;
		holdGroup = 1'b0;
		heldLast = 1'b0;
		heldPcVal = '0;
		seenCount = 0;
		predCount = 0;
		curName = "none";
		buildStimulus();
		totalGroups = pcQ.size();
		// three cycles per group at best and plenty of room for stalls
		cycleLimit = 3 * totalGroups * 20 + resetCycles + 20;
		repeat (resetCycles) @(negedge clk2x);
		rst = 1'b0;
		repeat (3) begin
			@(negedge clk2x);
			#1;
			checkValue("idleAfterReset", 32'd0, {31'd0, predValid});
			checkValue("idleAfterReset", 32'd1, {31'd0, grpReady});
		end
		while (predCount < totalGroups) begin
			runCycle();
		end
		// the queues are empty now, so the DUT must stay quiet
		repeat (4) begin
			runCycle();
			checkValue("noExtraPrediction", 32'd0, {31'd0, predValid});
		end
		$display("Simulation completed successfully");
		$finish;
	end

	// watchdog on rising edges
	always @(posedge clk2x) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
			abortRun($sformatf("Timeout after %0d cycles with %0d of %0d predictions checked",
				cycleCount, predCount, totalGroups));
		end
	end

endmodule

// File: include/fetchPredict.svh
// shared macros for the fetch predictor RTL
// holds the clocking used by every concurrent assertion
`ifndef FETCH_PREDICT_SVH
`define FETCH_PREDICT_SVH
// ==================================================
`define fpAssertClk @(posedge clk2x) disable iff (rst)
// ==================================================
`endif

// File: project.f
+incdir+include
rtl/fetchPredictPkg.sv
rtl/groupDecode.sv
rtl/returnStack.sv
rtl/nextPcPredict.sv
rtl/fetchPredictTop.sv
bench/fetchPredictModel.sv
bench/fetchPredictTb.sv

// File: rtl/fetchPredictPkg.sv
// fetch predictor package
// widths, reset PC, default stack depth, slot count
// instruction field layout and the slot kind enum
package fetchPredictPkg;

	// ==================================================
	// widths and constants
	// ==================================================
	localparam int unsigned addrWidth = 32;
	localparam int unsigned instrWidth = 32;
	localparam int unsigned regWidth = 7;
	localparam int unsigned slotCount = 2;
	localparam int unsigned stackDepth = 16;

	// a jump that links to this register is a plain jump and never pushes
	localparam logic [regWidth-1:0] noLinkReg = 7'd96;

	// stack entries and the first prediction come out of reset with this PC
	localparam logic [addrWidth-1:0] resetPc = 32'hFFFFE000;

	// ==================================================
	// instruction field layout
	// ==================================================
	// opcode class in the two low bits
	localparam int unsigned classLsb = 0;
	localparam int unsigned classMsb = 1;
	localparam logic [1:0] classJal = 2'd1;
	localparam logic [1:0] classRet = 2'd2;

	// length in bytes, a zero field counts as one byte
	localparam int unsigned lenLsb = 2;
	localparam int unsigned lenMsb = 4;
	localparam int unsigned lenWidth = lenMsb - lenLsb + 1;

	// link register of a jump
	localparam int unsigned linkLsb = 5;
	localparam int unsigned linkMsb = 11;

	// signed target offset, relative to the slot's own PC
	localparam int unsigned offLsb = 12;
	localparam int unsigned offMsb = 31;
	localparam int unsigned offWidth = offMsb - offLsb + 1;

	// what a slot does to control flow and to the return stack
	typedef enum logic [1:0] {
		kindOther = 2'd0,
		kindCall = 2'd1,
		kindJump = 2'd2,
		kindRet = 2'd3
	} slotKindT;

endpackage

// File: rtl/fetchPredictTop.sv
// top level of the fetch return-address predictor
// connects the predecoder, the return stack and the next-PC sequencer
`timescale 1ns/10ps

module fetchPredictTop (
	input  logic                                   clk2x,
	input  logic                                   rst,
	input  logic                                   grpValid,
	output logic                                   grpReady,
	input  logic [fetchPredictPkg::addrWidth-1:0]  grpPc,
	input  logic [fetchPredictPkg::instrWidth-1:0] grpInstr0,
	input  logic [fetchPredictPkg::instrWidth-1:0] grpInstr1,
	input  logic [fetchPredictPkg::slotCount-1:0]  grpSlotValid,
	output logic                                   predValid,
	input  logic                                   predReady,
	output logic [fetchPredictPkg::addrWidth-1:0]  predPc
);
	import fetchPredictPkg::*;

	// held group, fed back into the predecoder
	logic [addrWidth-1:0] heldPc;
	logic [instrWidth-1:0] heldInstr0;
	logic [instrWidth-1:0] heldInstr1;
	logic [slotCount-1:0] heldSlotValid;

	// predecoder results
	slotKindT kind0;
	slotKindT kind1;
	logic [addrWidth-1:0] retAddr0;
	logic [addrWidth-1:0] retAddr1;
	logic [addrWidth-1:0] target0;
	logic [addrWidth-1:0] target1;
	logic [addrWidth-1:0] fallPc;

	// stack control and top of stack
	logic stackPhase;
	logic pushEn;
	logic popEn;
	logic [addrWidth-1:0] pushAddr;
	logic [addrWidth-1:0] topAddr;

	groupDecode uDecode (
		.pc(heldPc), .instr0(heldInstr0), .instr1(heldInstr1), .slotValid(heldSlotValid),
		.kind0(kind0), .kind1(kind1), .retAddr0(retAddr0), .retAddr1(retAddr1),
		.target0(target0), .target1(target1), .fallPc(fallPc)
	);

	returnStack #(.depth(stackDepth)) uStack (
		.clk2x(clk2x), .rst(rst), .stackPhase(stackPhase), .pushEn(pushEn),
		.popEn(popEn), .pushAddr(pushAddr), .topAddr(topAddr)
	);

	nextPcPredict uPredict (
		.clk2x(clk2x), .rst(rst), .grpValid(grpValid), .grpReady(grpReady),
		.grpPc(grpPc), .grpInstr0(grpInstr0), .grpInstr1(grpInstr1),
		.grpSlotValid(grpSlotValid), .heldPc(heldPc), .heldInstr0(heldInstr0),
		.heldInstr1(heldInstr1), .heldSlotValid(heldSlotValid), .kind0(kind0),
		.kind1(kind1), .retAddr0(retAddr0), .retAddr1(retAddr1), .target0(target0),
		.target1(target1), .fallPc(fallPc), .topAddr(topAddr), .stackPhase(stackPhase),
		.pushEn(pushEn), .popEn(popEn), .pushAddr(pushAddr), .predValid(predValid),
		.predReady(predReady), .predPc(predPc)
	);

endmodule

// File: rtl/groupDecode.sv
// two-slot predecoder for a fetch group
// classifies each slot as call, plain jump, return or other
// and works out slot lengths, return addresses, targets and fall-through
`timescale 1ns/10ps

module groupDecode (
	input  logic [fetchPredictPkg::addrWidth-1:0]  pc,
	input  logic [fetchPredictPkg::instrWidth-1:0] instr0,
	input  logic [fetchPredictPkg::instrWidth-1:0] instr1,
	input  logic [fetchPredictPkg::slotCount-1:0]  slotValid,
	output fetchPredictPkg::slotKindT              kind0,
	output fetchPredictPkg::slotKindT              kind1,
	output logic [fetchPredictPkg::addrWidth-1:0]  retAddr0,
	output logic [fetchPredictPkg::addrWidth-1:0]  retAddr1,
	output logic [fetchPredictPkg::addrWidth-1:0]  target0,
	output logic [fetchPredictPkg::addrWidth-1:0]  target1,
	output logic [fetchPredictPkg::addrWidth-1:0]  fallPc
);
	import fetchPredictPkg::*;

	logic [addrWidth-1:0] len0;
	logic [addrWidth-1:0] len1;
	logic [addrWidth-1:0] pc1;

	// ==================================================
	// per-slot field decode
	// ==================================================

	// a jump-and-link only counts as a call when it really writes a link register
	function automatic slotKindT slotKind(
		input logic [instrWidth-1:0] instr,
		input logic                  valid
	);
		logic [1:0] opClass;
		logic [regWidth-1:0] link;
		opClass = instr[classMsb:classLsb];
		link = instr[linkMsb:linkLsb];
		if (!valid) begin
			return kindOther;
		end
		if (opClass == classJal) begin
			return (link == noLinkReg) ? kindJump : kindCall;
		end
		if (opClass == classRet) begin
			return kindRet;
		end
		return kindOther;
	endfunction

	// length field widened to an address, a zero length is taken as one byte
	function automatic logic [addrWidth-1:0] slotLen(input logic [instrWidth-1:0] instr);
		logic [lenWidth-1:0] raw;
		raw = instr[lenMsb:lenLsb];
		if (raw == '0) begin
			raw = lenWidth'(1);
		end
		return addrWidth'(raw);
	endfunction

	// offset is signed, so the size cast sign-extends it
	function automatic logic [addrWidth-1:0] slotOffset(input logic [instrWidth-1:0] instr);
		logic signed [offWidth-1:0] off;
		off = instr[offMsb:offLsb];
		return addrWidth'(off);
	endfunction

	// ==================================================
	// slot addresses
	// ==================================================
	assign len0 = slotLen(instr0);
	assign len1 = slotLen(instr1);

	// slot 1 starts right after slot 0
	assign pc1 = pc + len0;

	assign kind0 = slotKind(instr0, slotValid[0]);
	assign kind1 = slotKind(instr1, slotValid[1]);

	// return address is the byte after the calling slot
	assign retAddr0 = pc1;
	assign retAddr1 = pc1 + len1;

	assign target0 = pc + slotOffset(instr0);
	assign target1 = pc1 + slotOffset(instr1);

	// sequential path past both slots
	assign fallPc = retAddr1;

endmodule

// File: rtl/nextPcPredict.sv
// group sequencer and next fetch PC chooser
// holds one accepted group, runs phase 0 and phase 1 against the stack
// and hands the chosen PC out on a valid/ready handshake
`timescale 1ns/10ps
`include "fetchPredict.svh"

module nextPcPredict (
	input  logic                                   clk2x,
	input  logic                                   rst,
	input  logic                                   grpValid,
	output logic                                   grpReady,
	input  logic [fetchPredictPkg::addrWidth-1:0]  grpPc,
	input  logic [fetchPredictPkg::instrWidth-1:0] grpInstr0,
	input  logic [fetchPredictPkg::instrWidth-1:0] grpInstr1,
	input  logic [fetchPredictPkg::slotCount-1:0]  grpSlotValid,
	output logic [fetchPredictPkg::addrWidth-1:0]  heldPc,
	output logic [fetchPredictPkg::instrWidth-1:0] heldInstr0,
	output logic [fetchPredictPkg::instrWidth-1:0] heldInstr1,
	output logic [fetchPredictPkg::slotCount-1:0]  heldSlotValid,
	input  fetchPredictPkg::slotKindT              kind0,
	input  fetchPredictPkg::slotKindT              kind1,
	input  logic [fetchPredictPkg::addrWidth-1:0]  retAddr0,
	input  logic [fetchPredictPkg::addrWidth-1:0]  retAddr1,
	input  logic [fetchPredictPkg::addrWidth-1:0]  target0,
	input  logic [fetchPredictPkg::addrWidth-1:0]  target1,
	input  logic [fetchPredictPkg::addrWidth-1:0]  fallPc,
	input  logic [fetchPredictPkg::addrWidth-1:0]  topAddr,
	output logic                                   stackPhase,
	output logic                                   pushEn,
	output logic                                   popEn,
	output logic [fetchPredictPkg::addrWidth-1:0]  pushAddr,
	output logic                                   predValid,
	input  logic                                   predReady,
	output logic [fetchPredictPkg::addrWidth-1:0]  predPc
);
	import fetchPredictPkg::*;

	logic busy;
	logic accept;
	logic slotActive;
	logic recordPc;
	slotKindT slotKind;
	logic [addrWidth-1:0] slotTarget;
	logic [addrWidth-1:0] chosenPc;

	// a new group may enter in the same cycle the previous prediction leaves
	assign grpReady = !busy && (!predValid || predReady);
	assign accept = grpValid && grpReady;

	always_ff @(posedge clk2x) begin
		if (accept) begin
			heldPc <= grpPc;
			heldInstr0 <= grpInstr0;
			heldInstr1 <= grpInstr1;
			heldSlotValid <= grpSlotValid;
		end
	end

	// ==================================================
	// phase sequencer
	// ==================================================
	always_ff @(posedge clk2x) begin
		if (rst) begin
			busy <= 1'b0;
			stackPhase <= 1'b0;
			predValid <= 1'b0;
		end else begin
			if (predValid && predReady) begin
				predValid <= 1'b0;
			end
			if (accept) begin
				busy <= 1'b1;
				stackPhase <= 1'b0;
			end else if (busy && !stackPhase) begin
				stackPhase <= 1'b1;
			end else if (busy) begin
				// phase 1 is done, the prediction is ready on the next cycle
				busy <= 1'b0;
				stackPhase <= 1'b0;
				predValid <= 1'b1;
			end
		end
	end

	// slot 1 only gets a say when slot 0 is ordinary
	always_comb begin
		slotKind = stackPhase ? kind1 : kind0;
		slotTarget = stackPhase ? target1 : target0;
		pushAddr = stackPhase ? retAddr1 : retAddr0;
		slotActive = busy && (!stackPhase || kind0 == kindOther);
		pushEn = slotActive && slotKind == kindCall;
		popEn = slotActive && slotKind == kindRet;
		recordPc = busy && (stackPhase ? kind0 == kindOther : kind0 != kindOther);
		// topAddr here is still the value before this phase's pop lands
		case (slotKind)
			kindRet: chosenPc = topAddr;
			kindCall, kindJump: chosenPc = slotTarget;
			default: chosenPc = fallPc;
		endcase
	end

	always_ff @(posedge clk2x) begin
		if (recordPc) begin
			predPc <= chosenPc;
		end
	end

	// a held prediction must not move under back-pressure
	aPredHeld: assert property (
		`fpAssertClk predValid && !predReady |=> predValid && $stable(predPc)
	) else $error("predPc changed while the prediction was stalled");

endmodule

// File: rtl/returnStack.sv
// circular return address stack
// slot 0 acts in phase 0 and slot 1 in phase 1, one push or pop per cycle
// grows downward, so a push pre-decrements and a pop post-increments
`timescale 1ns/10ps
`include "fetchPredict.svh"

module returnStack #(
	parameter int unsigned depth = 16
) (
	input  logic                                  clk2x,
	input  logic                                  rst,
	input  logic                                  stackPhase,
	input  logic                                  pushEn,
	input  logic                                  popEn,
	input  logic [fetchPredictPkg::addrWidth-1:0] pushAddr,
	output logic [fetchPredictPkg::addrWidth-1:0] topAddr
);
	import fetchPredictPkg::*;

	// pointer arithmetic wraps on its own, which is what makes the buffer circular
	localparam int unsigned ptrWidth = $clog2(depth);

	logic [addrWidth-1:0] entries [depth];
	logic [ptrWidth-1:0] stackPtr;
	logic [ptrWidth-1:0] pushPtr;

	// ==================================================
	// elaboration check
	// ==================================================

	// the wrap only works when depth fills the pointer exactly
	if (depth < 2 || (depth & (depth - 1)) != 0) begin : gDepthCheck
		$error("returnStack depth must be a power of two and at least 2");
	end

	// ==================================================
	// stack update
	// ==================================================

	// the slot being pushed lands just below the current top
	assign pushPtr = stackPtr - 1'b1;

	always_ff @(posedge clk2x) begin
		if (rst) begin
			// every entry starts out at the reset PC
			for (int i = 0; i < depth; i++) begin
				entries[i] <= resetPc;
			end
			stackPtr <= '0;
		end else if (pushEn) begin
			// overflow silently overwrites the oldest entry
			entries[pushPtr] <= pushAddr;
			stackPtr <= pushPtr;
		end else if (popEn) begin
			// popped entry stays in place and comes back on underflow
			stackPtr <= stackPtr + 1'b1;
		end
	end

	// top is read straight out of the array, no extra cycle
	assign topAddr = entries[stackPtr];

	// ==================================================
	// checks
	// ==================================================

	// the sequencer only ever asks for one operation per slot
	aPushPopExclusive: assert property (
		`fpAssertClk !(pushEn && popEn)
	) else $error("returnStack got push and pop in the same cycle");

	// slot 1 must stay quiet once slot 0 has touched the stack
	aOneOpPerGroup: assert property (
		`fpAssertClk (pushEn || popEn) && !stackPhase |=> !(pushEn || popEn)
	) else $error("returnStack saw two operations in one fetch group");

endmodule
